//--- hw/ExecPkg.sv
package ExecPkg;

typedef logic [6:0] Tag_t;
typedef logic [7:0] SqN_t;
typedef logic [2:0] FetchID_t;
typedef logic [2:0] FetchOff_t;

typedef enum logic [2:0] {
    OP_ADD   = 3'd0,
    OP_SUB   = 3'd1,
    OP_AND   = 3'd2,
    OP_XOR   = 3'd3,
    OP_AUIPC = 3'd4
} Opcode_t;

// Source tag seen either as a register index or as a small signed constant
typedef union packed {
    struct packed {
        logic isImm;
        logic [5:0] idx;
    } regView;
    struct packed {
        logic isImm;
        logic signed [5:0] value;
    } immView;
} TagWord;

typedef struct packed {
    logic valid;
    TagWord tagA;
    TagWord tagB;
    logic immB;
    logic [31:0] imm;
    Tag_t tagDst;
    SqN_t sqN;
    FetchID_t fetchID;
    FetchOff_t fetchOffs;
    Opcode_t opcode;
} IssueUop;

typedef struct packed {
    logic valid;
    logic [31:0] srcA;
    logic [31:0] srcB;
    logic [31:0] imm;
    logic [31:0] pc;
    Tag_t tagDst;
    SqN_t sqN;
    Opcode_t opcode;
} ExUop;

typedef struct packed {
    logic valid;
    Tag_t tag;
    logic [31:0] result;
} ZCForward;

typedef struct packed {
    logic valid;
    Tag_t tagDst;
    SqN_t sqN;
    logic [31:0] result;
} ResultUop;

typedef struct packed {
    logic taken;
    SqN_t sqN;
} BranchFlush;

typedef struct packed {
    logic valid;
    logic [5:0] addr;
} RFReadReq;

typedef struct packed {
    logic valid;
    FetchID_t fetchID;
    logic [31:0] pc;
} PCWrite;

// Sequence numbers wrap, so age is the sign of the difference
function automatic logic isYounger(SqN_t a, SqN_t b);
    SqN_t diff;
    diff = a - b;
    return $signed(diff) > 0;
endfunction

// A destination with the flag bit set writes no register
function automatic logic hasDest(Tag_t t);
    return !t[$bits(Tag_t)-1];
endfunction

function automatic logic [31:0] tagConst(TagWord t);
    return {{26{t.immView.value[5]}}, t.immView.value};
endfunction

endpackage

//--- hw/RegFile.sv
`timescale 1ns/1ps

module RegFile #(
    parameter NUM_LANES = 2
) (
    input logic clk,
    input logic rst,
    input ExecPkg::RFReadReq rdReq[2*NUM_LANES],
    output logic [31:0] rdData[2*NUM_LANES],
    input ExecPkg::ResultUop wr[NUM_LANES]
);
    import ExecPkg::*;

    localparam NUM_READS = 2 * NUM_LANES;

    logic [31:0] mem[64];
    logic wrEn[NUM_LANES];

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            wrEn[i] = wr[i].valid && hasDest(wr[i].tagDst);
        end
    end

    // Higher lanes are written last and win on a shared address
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int a = 0; a < 64; a++) begin
                mem[a] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_LANES; i++) begin
                if (wrEn[i]) begin
                    mem[wr[i].tagDst[5:0]] <= wr[i].result;
                end
            end
        end
    end

    // Write-first read
    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_READS; p++) begin
            if (rdReq[p].valid) begin
                rdData[p] <= mem[rdReq[p].addr];
                for (int i = 0; i < NUM_LANES; i++) begin
                    if (wrEn[i] && wr[i].tagDst[5:0] == rdReq[p].addr) begin
                        rdData[p] <= wr[i].result;
                    end
                end
            end
        end
    end

    // Lanes that finish together must not share a destination
    for (genvar i = 0; i < NUM_LANES; i++) begin : gWrCheck
        for (genvar j = i + 1; j < NUM_LANES; j++) begin : gPair
            assert property (@(posedge clk) disable iff (rst)
                !(wrEn[i] && wrEn[j] && wr[i].tagDst == wr[j].tagDst))
                else $error("RegFile: lanes %0d and %0d write tag %h together",
                            i, j, wr[i].tagDst);
        end
    end

endmodule

//--- hw/PCFile.sv
`timescale 1ns/1ps

module PCFile #(
    parameter NUM_LANES = 2
) (
    input logic clk,
    input logic rst,
    input ExecPkg::PCWrite wr,
    input ExecPkg::FetchID_t rdID[NUM_LANES],
    output logic [31:0] rdData[NUM_LANES]
);
    import ExecPkg::*;

    localparam NUM_ENTRIES = 2 ** $bits(FetchID_t);

    // Base PC of each fetch block
    logic [31:0] entries[NUM_ENTRIES];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int e = 0; e < NUM_ENTRIES; e++) begin
                entries[e] <= '0;
            end
        end else if (wr.valid) begin
            entries[wr.fetchID] <= wr.pc;
        end
    end

    // Registered so the base arrives with the OperandLoad output register
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (wr.valid && wr.fetchID == rdID[i]) begin
                rdData[i] <= wr.pc;
            end else begin
                rdData[i] <= entries[rdID[i]];
            end
        end
    end

endmodule

//--- hw/OperandLoad.sv
`timescale 1ns/1ps

module OperandLoad #(
    parameter NUM_LANES = 2
) (
    input logic clk,
    input logic rst,
    input ExecPkg::IssueUop issue[NUM_LANES],
    input logic stall[NUM_LANES],
    input ExecPkg::BranchFlush flush,
    input ExecPkg::ZCForward zcFwd[NUM_LANES],
    input ExecPkg::ResultUop snoop[NUM_LANES],
    output ExecPkg::RFReadReq rfRead[2*NUM_LANES],
    input logic [31:0] rfData[2*NUM_LANES],
    output ExecPkg::FetchID_t pcReadID[NUM_LANES],
    input logic [31:0] pcData[NUM_LANES],
    output ExecPkg::ExUop exUop[NUM_LANES]
);
    import ExecPkg::*;

    localparam NUM_FWD = 2 * NUM_LANES;
    localparam NUM_LOOKUP = 2 * NUM_LANES;

    ZCForward fwd[NUM_FWD];
    Tag_t lookup[NUM_LOOKUP];
    logic fwdHit[NUM_LOOKUP];
    logic [31:0] fwdData[NUM_LOOKUP];

    logic [31:0] nextA[NUM_LANES];
    logic [31:0] nextB[NUM_LANES];
    logic nextPendA[NUM_LANES];
    logic nextPendB[NUM_LANES];

    logic accept[NUM_LANES];
    logic killHeld[NUM_LANES];

    ExUop uopReg[NUM_LANES];
    logic pendA[NUM_LANES];
    logic pendB[NUM_LANES];
    logic pendPc[NUM_LANES];

    // Zero-cycle forwards sit at the low indices and win
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            fwd[i] = zcFwd[i];
            fwd[NUM_LANES + i].valid = snoop[i].valid && hasDest(snoop[i].tagDst);
            fwd[NUM_LANES + i].tag = snoop[i].tagDst;
            fwd[NUM_LANES + i].result = snoop[i].result;
        end
    end

    // Ports 0..N-1 carry tagA, ports N..2N-1 carry tagB
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lookup[i] = issue[i].tagA;
            lookup[NUM_LANES + i] = issue[i].tagB;

            rfRead[i].valid = issue[i].valid && !issue[i].tagA.regView.isImm;
            rfRead[i].addr = issue[i].tagA.regView.idx;
            rfRead[NUM_LANES + i].valid = issue[i].valid && !issue[i].immB &&
                                          !issue[i].tagB.regView.isImm;
            rfRead[NUM_LANES + i].addr = issue[i].tagB.regView.idx;

            pcReadID[i] = issue[i].fetchID;
        end
    end

    always_comb begin
        for (int p = 0; p < NUM_LOOKUP; p++) begin
            fwdHit[p] = 1'b0;
            fwdData[p] = '0;
            for (int f = NUM_FWD - 1; f >= 0; f--) begin
                if (fwd[f].valid && fwd[f].tag == lookup[p]) begin
                    fwdHit[p] = 1'b1;
                    fwdData[p] = fwd[f].result;
                end
            end
        end
    end

    // Constant, then immediate, then forward, else left for the register file
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            nextA[i] = fwdData[i];
            nextPendA[i] = 1'b0;
            if (issue[i].tagA.regView.isImm) begin
                nextA[i] = tagConst(issue[i].tagA);
            end else if (!fwdHit[i]) begin
                nextPendA[i] = 1'b1;
            end

            nextB[i] = fwdData[NUM_LANES + i];
            nextPendB[i] = 1'b0;
            if (issue[i].tagB.regView.isImm) begin
                nextB[i] = tagConst(issue[i].tagB);
            end else if (issue[i].immB) begin
                nextB[i] = issue[i].imm;
            end else if (!fwdHit[NUM_LANES + i]) begin
                nextPendB[i] = 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            accept[i] = issue[i].valid && !stall[i] &&
                        !(flush.taken && isYounger(issue[i].sqN, flush.sqN));
            killHeld[i] = flush.taken && uopReg[i].valid &&
                          isYounger(uopReg[i].sqN, flush.sqN);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (rst) begin
                uopReg[i].valid <= 1'b0;
                pendA[i] <= 1'b0;
                pendB[i] <= 1'b0;
                pendPc[i] <= 1'b0;
            end else if (accept[i]) begin
                uopReg[i].valid <= 1'b1;
                uopReg[i].srcA <= nextA[i];
                uopReg[i].srcB <= nextB[i];
                uopReg[i].imm <= issue[i].imm;
                // Holds the block offset in bytes until the base arrives
                uopReg[i].pc <= {28'b0, issue[i].fetchOffs, 1'b0};
                uopReg[i].tagDst <= issue[i].tagDst;
                uopReg[i].sqN <= issue[i].sqN;
                uopReg[i].opcode <= issue[i].opcode;
                pendA[i] <= nextPendA[i];
                pendB[i] <= nextPendB[i];
                pendPc[i] <= 1'b1;
            end else if (!stall[i] || killHeld[i]) begin
                uopReg[i].valid <= 1'b0;
                pendA[i] <= 1'b0;
                pendB[i] <= 1'b0;
                pendPc[i] <= 1'b0;
            end else begin
                // Read ports move on to the held issue slot next cycle
                if (pendA[i]) begin
                    uopReg[i].srcA <= rfData[i];
                end
                if (pendB[i]) begin
                    uopReg[i].srcB <= rfData[NUM_LANES + i];
                end
                if (pendPc[i]) begin
                    uopReg[i].pc <= pcData[i] + uopReg[i].pc;
                end
                pendA[i] <= 1'b0;
                pendB[i] <= 1'b0;
                pendPc[i] <= 1'b0;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            exUop[i] = uopReg[i];
            exUop[i].valid = uopReg[i].valid && !stall[i] && !killHeld[i];
            if (pendA[i]) begin
                exUop[i].srcA = rfData[i];
            end
            if (pendB[i]) begin
                exUop[i].srcB = rfData[NUM_LANES + i];
            end
            if (pendPc[i]) begin
                exUop[i].pc = pcData[i] + uopReg[i].pc;
            end
        end
    end

    // A stalled issue slot keeps its micro-op until taken or flushed
    for (genvar i = 0; i < NUM_LANES; i++) begin : gHoldCheck
        assert property (@(posedge clk) disable iff (rst)
            stall[i] && issue[i].valid &&
                !(flush.taken && isYounger(issue[i].sqN, flush.sqN)) |=>
                issue[i].valid && issue[i].sqN == $past(issue[i].sqN))
            else $error("OperandLoad: lane %0d issue changed while stalled", i);
    end

endmodule

//--- hw/IntExecute.sv
`timescale 1ns/1ps

module IntExecute #(
    parameter NUM_LANES = 2
) (
    input logic clk,
    input logic rst,
    input ExecPkg::ExUop exUop[NUM_LANES],
    output ExecPkg::ZCForward zcFwd[NUM_LANES],
    output ExecPkg::ResultUop result[NUM_LANES]
);
    import ExecPkg::*;

    logic [31:0] aluOut[NUM_LANES];

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            case (exUop[i].opcode)
                OP_ADD:   aluOut[i] = exUop[i].srcA + exUop[i].srcB;
                OP_SUB:   aluOut[i] = exUop[i].srcA - exUop[i].srcB;
                OP_AND:   aluOut[i] = exUop[i].srcA & exUop[i].srcB;
                OP_XOR:   aluOut[i] = exUop[i].srcA ^ exUop[i].srcB;
                OP_AUIPC: aluOut[i] = exUop[i].pc + exUop[i].imm;
                default:  aluOut[i] = '0;
            endcase
        end
    end

    // Same-cycle forward for back-to-back dependents
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            zcFwd[i].valid = exUop[i].valid && hasDest(exUop[i].tagDst);
            zcFwd[i].tag = exUop[i].tagDst;
            zcFwd[i].result = aluOut[i];
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            result[i].tagDst <= exUop[i].tagDst;
            result[i].sqN <= exUop[i].sqN;
            result[i].result <= aluOut[i];
            if (rst) begin
                result[i].valid <= 1'b0;
            end else begin
                result[i].valid <= exUop[i].valid;
            end
        end
    end

    // Only decoded opcodes reach the ALU
    for (genvar i = 0; i < NUM_LANES; i++) begin : gOpcodeCheck
        assert property (@(posedge clk) disable iff (rst)
            exUop[i].valid |->
                exUop[i].opcode inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_AUIPC})
            else $error("IntExecute: lane %0d got unknown opcode %h", i, exUop[i].opcode);
    end

endmodule

//--- hw/ExecCore.sv
`timescale 1ns/1ps

module ExecCore #(
    parameter NUM_LANES = 2
) (
    input logic clk,
    input logic rst,
    input ExecPkg::IssueUop issue[NUM_LANES],
    input logic stall[NUM_LANES],
    input ExecPkg::BranchFlush flush,
    input ExecPkg::PCWrite pcWrite,
    output ExecPkg::ResultUop result[NUM_LANES]
);
    import ExecPkg::*;

    RFReadReq rfRead[2*NUM_LANES];
    logic [31:0] rfData[2*NUM_LANES];
    FetchID_t pcReadID[NUM_LANES];
    logic [31:0] pcData[NUM_LANES];
    ExUop exUop[NUM_LANES];
    ZCForward zcFwd[NUM_LANES];

    RegFile #(
        .NUM_LANES(NUM_LANES)
    ) regFile0 (
        .clk(clk),
        .rst(rst),
        .rdReq(rfRead),
        .rdData(rfData),
        .wr(result)
    );

    PCFile #(
        .NUM_LANES(NUM_LANES)
    ) pcFile0 (
        .clk(clk),
        .rst(rst),
        .wr(pcWrite),
        .rdID(pcReadID),
        .rdData(pcData)
    );

    OperandLoad #(
        .NUM_LANES(NUM_LANES)
    ) operandLoad0 (
        .clk(clk),
        .rst(rst),
        .issue(issue),
        .stall(stall),
        .flush(flush),
        .zcFwd(zcFwd),
        .snoop(result),
        .rfRead(rfRead),
        .rfData(rfData),
        .pcReadID(pcReadID),
        .pcData(pcData),
        .exUop(exUop)
    );

    // Result bus feeds the core output, the register file and the snoop path
    IntExecute #(
        .NUM_LANES(NUM_LANES)
    ) intExecute0 (
        .clk(clk),
        .rst(rst),
        .exUop(exUop),
        .zcFwd(zcFwd),
        .result(result)
    );

endmodule

//--- testbench/ExecCoreChecker.sv
`timescale 1ns/1ps

module ExecCoreChecker #(
    parameter NUM_LANES = 2
) (
    input logic clk,
    input logic rst,
    input ExecPkg::IssueUop issue[NUM_LANES],
    input logic stall[NUM_LANES],
    input ExecPkg::BranchFlush flush,
    input ExecPkg::PCWrite pcWrite,
    input ExecPkg::ResultUop result[NUM_LANES],
    output int valueErrors,
    output int unexpected,
    output int timingErrors,
    output int pending
);
    import ExecPkg::*;

    typedef struct packed {
        ResultUop res;
        int unsigned due;
    } ExpEntry;

    logic [31:0] regModel[64];
    logic [31:0] pcModel[8];
    IssueUop slot[NUM_LANES];
    ExpEntry expQ[NUM_LANES][$];
    int unsigned cycle;

    function automatic logic youngerThan(SqN_t a, SqN_t b);
        logic [7:0] d;
        d = a - b;
        return !d[7] && d != 0;
    endfunction

    // Flag bit set means a sign-extended 6-bit constant
    function automatic logic [31:0] sourceValue(logic [6:0] tag);
        if (tag[6]) begin
            return {{26{tag[5]}}, tag[5:0]};
        end
        return regModel[tag[5:0]];
    endfunction

    function automatic logic [31:0] refResult(Opcode_t op, logic [31:0] a, logic [31:0] b,
                                              logic [31:0] pc, logic [31:0] imm);
        case (op)
            OP_ADD: return a + b;
            OP_SUB: return a - b;
            OP_AND: return a & b;
            OP_XOR: return a ^ b;
            OP_AUIPC: return pc + imm;
            default: return '0;
        endcase
    endfunction

    task automatic queueExpected(int l);
        IssueUop u;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc;
        ExpEntry e;
        u = slot[l];
        a = sourceValue(u.tagA);
        b = (u.immB && !u.tagB[6]) ? u.imm : sourceValue(u.tagB);
        pc = pcModel[u.fetchID] + {28'b0, u.fetchOffs, 1'b0};
        e.res.valid = 1'b1;
        e.res.tagDst = u.tagDst;
        e.res.sqN = u.sqN;
        e.res.result = refResult(u.opcode, a, b, pc, u.imm);
        e.due = cycle + 1;
        if (!u.tagDst[6]) begin
            regModel[u.tagDst[5:0]] = e.res.result;
        end
        expQ[l].push_back(e);
    endtask

    task automatic checkResult(int l);
        ExpEntry e;
        if (!result[l].valid) begin
            return;
        end
        if (expQ[l].size() == 0) begin
            unexpected++;
            $display("Lane %0d produced a result for sqN %h that no micro-op expects",
                     l, result[l].sqN);
            return;
        end
        e = expQ[l].pop_front();
        if (cycle != e.due) begin
            timingErrors++;
            $display("Lane %0d result for sqN %h came in cycle %0d instead of %0d",
                     l, e.res.sqN, cycle, e.due);
        end
        if (result[l].sqN != e.res.sqN) begin
            valueErrors++;
            $display("error: result[%0d].sqN got %h expected %h", l, result[l].sqN, e.res.sqN);
        end
        if (result[l].tagDst != e.res.tagDst) begin
            valueErrors++;
            $display("error: result[%0d].tagDst got %h expected %h",
                     l, result[l].tagDst, e.res.tagDst);
        end
        if (result[l].result != e.res.result) begin
            valueErrors++;
            $display("error: result[%0d].result got %h expected %h",
                     l, result[l].result, e.res.result);
        end
    endtask

    initial begin
        valueErrors = 0;
        unexpected = 0;
        timingErrors = 0;
        pending = 0;
    end

    // Negative edge, where inputs and registered outputs are both settled
    always @(negedge clk) begin
        if (rst) begin
            cycle = 0;
            for (int r = 0; r < 64; r++) begin
                regModel[r] = '0;
            end
            for (int p = 0; p < 8; p++) begin
                pcModel[p] = '0;
            end
            for (int l = 0; l < NUM_LANES; l++) begin
                slot[l] = '0;
                expQ[l].delete();
            end
        end else begin
            cycle++;
            if (pcWrite.valid) begin
                pcModel[pcWrite.fetchID] = pcWrite.pc;
            end
            pending = 0;
            for (int l = 0; l < NUM_LANES; l++) begin
                checkResult(l);
                if (slot[l].valid) begin
                    if (flush.taken && youngerThan(slot[l].sqN, flush.sqN)) begin
                        slot[l].valid = 1'b0;
                    end else if (!stall[l]) begin
                        queueExpected(l);
                        slot[l].valid = 1'b0;
                    end
                end
                if (issue[l].valid && !stall[l] &&
                    !(flush.taken && youngerThan(issue[l].sqN, flush.sqN))) begin
                    slot[l] = issue[l];
                end
                pending += expQ[l].size() + (slot[l].valid ? 1 : 0);
            end
        end
    end

endmodule

//--- testbench/ExecCoreTb.sv
`timescale 1ns/1ps

module ExecCoreTb;
    import ExecPkg::*;

    localparam int NUM_LANES = 2;
    localparam int CYCLES_PER_PHASE = 40;
    localparam int NUM_PHASES = 5;
    localparam int MAX_UOPS = NUM_LANES * CYCLES_PER_PHASE * NUM_PHASES;
    localparam int MAX_STALLS = 60;
    localparam int CYCLE_LIMIT = 3 * MAX_UOPS + MAX_STALLS + 50;
    localparam logic [15:0] SEED = 16'd20;

    logic clk;
    logic rst;
    IssueUop issue[NUM_LANES];
    logic stall[NUM_LANES];
    BranchFlush flush;
    PCWrite pcWrite;
    ResultUop result[NUM_LANES];

    int valueErrors;
    int unexpected;
    int timingErrors;
    int pending;

    logic [15:0] lfsrState;
    SqN_t nextSqN;
    int stallsLeft;
    int issuedCount;
    int cycleCount;

    ExecCore #(
        .NUM_LANES(NUM_LANES)
    ) dut0 (
        .clk(clk),
        .rst(rst),
        .issue(issue),
        .stall(stall),
        .flush(flush),
        .pcWrite(pcWrite),
        .result(result)
    );

    ExecCoreChecker #(
        .NUM_LANES(NUM_LANES)
    ) checker0 (
        .clk(clk),
        .rst(rst),
        .issue(issue),
        .stall(stall),
        .flush(flush),
        .pcWrite(pcWrite),
        .result(result),
        .valueErrors(valueErrors),
        .unexpected(unexpected),
        .timingErrors(timingErrors),
        .pending(pending)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] randBits(int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic logic youngerThan(SqN_t a, SqN_t b);
        logic [7:0] d;
        d = a - b;
        return !d[7] && d != 0;
    endfunction

    // Each lane keeps to its own half of the registers
    function automatic Tag_t laneReg(int lane);
        return {1'b0, lane[0], 2'b00, 3'(randBits(3))};
    endfunction

    function automatic IssueUop makeUop(int lane, int mode);
        IssueUop u;
        u = '0;
        u.valid = 1'b1;
        u.sqN = nextSqN;
        nextSqN = nextSqN + 1;
        u.tagDst = laneReg(lane);
        u.imm = randBits(32);
        u.fetchID = FetchID_t'(randBits(3));
        u.fetchOffs = FetchOff_t'(randBits(3));
        u.opcode = (mode == 4) ? OP_AUIPC : Opcode_t'(3'(randBits(2)));
        if (mode == 0) begin
            u.tagA = {1'b1, 6'(randBits(6))};
            if (randBits(1)) begin
                u.tagB = {1'b1, 6'(randBits(6))};
            end else begin
                u.tagB = laneReg(lane);
                u.immB = 1'b1;
            end
        end else begin
            u.tagA = laneReg(lane);
            u.tagB = laneReg(lane);
            u.immB = (randBits(2) == 0);
        end
        return u;
    endfunction

    task automatic runPhase(int mode);
        logic used;
        repeat (CYCLES_PER_PHASE) begin
            @(posedge clk);
            #2;
            for (int l = 0; l < NUM_LANES; l++) begin
                // Taken at this edge, or dropped by the flush of the last cycle
                used = issue[l].valid && (!stall[l] ||
                       (flush.taken && youngerThan(issue[l].sqN, flush.sqN)));
                if (!issue[l].valid || used) begin
                    if (randBits(3) == 0) begin
                        issue[l] = '0;
                    end else begin
                        issue[l] = makeUop(l, mode);
                        issuedCount++;
                    end
                end
                stall[l] = 1'b0;
                if ((mode == 2 || mode == 3) && stallsLeft > 0 && randBits(2) == 0) begin
                    stall[l] = 1'b1;
                    stallsLeft--;
                end
            end
            flush = '0;
            if (mode == 3 && randBits(3) == 0) begin
                flush.taken = 1'b1;
                flush.sqN = nextSqN - 3;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        flush = '0;
        pcWrite = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            issue[l] = '0;
            stall[l] = 1'b0;
        end
        lfsrState = SEED;
        nextSqN = '0;
        stallsLeft = MAX_STALLS;
        issuedCount = 0;
        cycleCount = 0;

        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        for (int id = 0; id < 8; id++) begin
            @(posedge clk);
            #2;
            pcWrite.valid = 1'b1;
            pcWrite.fetchID = FetchID_t'(id);
            pcWrite.pc = {24'(randBits(24)), 8'h00};
        end
        @(posedge clk);
        #2;
        pcWrite = '0;

        for (int mode = 0; mode < NUM_PHASES; mode++) begin
            runPhase(mode);
        end

        @(posedge clk);
        #2;
        flush = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            issue[l] = '0;
            stall[l] = 1'b0;
        end
        while (pending != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);

        $display("Issued %0d, errors: value %0d, unexpected %0d, timing %0d, missing %0d",
                 issuedCount, valueErrors, unexpected, timingErrors, pending);
        if (valueErrors == 0 && unexpected == 0 && timingErrors == 0 && pending == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- filelist.f
hw/ExecPkg.sv
hw/RegFile.sv
hw/PCFile.sv
hw/OperandLoad.sv
hw/IntExecute.sv
hw/ExecCore.sv
testbench/ExecCoreChecker.sv
testbench/ExecCoreTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= ExecCoreTb
FILELIST  ?= filelist.f

.PHONY: help test clean build

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

test: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir
